//--- sources.f
+incdir+design
design/pix_pkg.sv
design/ctrl_pkg.sv
design/feature_mem_arbiter.sv
design/window_fetcher.sv
design/conv_5x5.sv
design/conv_engine_top.sv
tb/conv_engine_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compiles the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module conv_engine_tb \
    -o conv_engine_sim > build.log 2>&1 \
  && ./obj_dir/conv_engine_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "CHECKS FAILED" sim.log \
  && { echo "simulation reported failures, see sim.log"; exit 1; } \
  || { echo "simulation finished without failures"; exit 0; }

//--- tb/conv_engine_tb.sv
`default_nettype none

`include "conv_defs.svh"

module conv_engine_tb;

  localparam int RUN_TIMEOUT = 20000;
  localparam int NUM_PIX     = `CONV_IMG_W * `CONV_IMG_H;

  logic                     clk;
  logic                     rst_n;
  logic                     pix_wr;
  logic [`CONV_ADDR_W-1:0]  pix_addr;
  pix_pkg::pixel_t          pix_wdata;
  logic                     coef_wr;
  logic [`CONV_KADDR_W-1:0] coef_idx;
  pix_pkg::coef_t           coef_wdata;
  logic                     start;
  logic                     busy;
  logic                     out_valid;
  pix_pkg::sum_t            out_data;
  logic                     done;

  pix_pkg::pixel_t image [0:NUM_PIX-1];  // model copy of the pixel RAM.
  pix_pkg::coef_t  kernel [0:`CONV_KK-1];
  pix_pkg::sum_t   exp_q [$];
  pix_pkg::sum_t   exp_val;
  int              out_count;
  int              errors;
  int              tests_run;
  int              tests_failed;
  int              errs_before;

  conv_engine_top u_conv_engine_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_wr     (pix_wr),
    .pix_addr   (pix_addr),
    .pix_wdata  (pix_wdata),
    .coef_wr    (coef_wr),
    .coef_idx   (coef_idx),
    .coef_wdata (coef_wdata),
    .start      (start),
    .busy       (busy),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .done       (done)
  );

  always #10 clk = ~clk;

  // each result leaves in raster order, so the queue front is always the next one.
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid at time %0t arrived with no result left to expect", $time);
        errors++;
      end else begin
        exp_val = exp_q.pop_front();
        if (out_data !== exp_val) begin
          $display("CHECK FAILED time %0t out_data got %0d expected %0d", $time, out_data,
                   exp_val);
          errors++;
        end
      end
      out_count++;
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED time %0t %s got %0b expected %0b", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic pix_pkg::sum_t window_sum(input int orow, input int ocol);
    int acc;
    acc = 0;
    for (int r = 0; r < `CONV_K; r++) begin
      for (int c = 0; c < `CONV_K; c++) begin
        acc += int'(image[(orow + r) * `CONV_IMG_W + ocol + c]) * int'(kernel[r * `CONV_K + c]);
      end
    end
    return pix_pkg::sum_t'(acc);
  endfunction

  task automatic load_image();
    for (int a = 0; a < NUM_PIX; a++) begin
      @(posedge clk);
      pix_wr    <= 1'b1;
      pix_addr  <= `CONV_ADDR_W'(a);
      pix_wdata <= image[a];
    end
    @(posedge clk);
    pix_wr <= 1'b0;
  endtask

  task automatic load_kernel();
    for (int k = 0; k < `CONV_KK; k++) begin
      @(posedge clk);
      coef_wr    <= 1'b1;
      coef_idx   <= `CONV_KADDR_W'(k);
      coef_wdata <= kernel[k];
    end
    @(posedge clk);
    coef_wr <= 1'b0;
  endtask

  // contend rewrites pixels with their own values. extra_start pulses start mid-run.
  task automatic run_conv(input bit contend, input bit extra_start);
    int  cyc;
    bit  seen_done;
    bit  prev_busy;
    bit  prev_valid;
    bit  extra_sent;
    logic [`CONV_ADDR_W-1:0] addr;
    exp_q.delete();
    for (int r = 0; r < `CONV_OUT_H; r++) begin
      for (int c = 0; c < `CONV_OUT_W; c++) begin
        exp_q.push_back(window_sum(r, c));
      end
    end
    out_count  = 0;
    cyc        = 0;
    seen_done  = 1'b0;
    prev_busy  = 1'b0;
    prev_valid = 1'b0;
    extra_sent = 1'b0;
    @(posedge clk);
    start <= 1'b1;
    while (!seen_done && cyc < RUN_TIMEOUT) begin
      @(posedge clk);
      start  <= 1'b0;
      pix_wr <= 1'b0;
      if (contend && ($urandom % 3 == 0)) begin
        addr = `CONV_ADDR_W'($urandom);
        pix_wr    <= 1'b1;
        pix_addr  <= addr;
        pix_wdata <= image[addr];
      end
      if (extra_start && !extra_sent && prev_busy && cyc >= 300) begin
        start <= 1'b1;  // must be ignored while busy.
        extra_sent = 1'b1;
      end
      @(negedge clk);
      if (cyc == 0) begin
        check_bit("busy", busy, 1'b1);
      end
      if (done) begin
        seen_done = 1'b1;
        check_bit("busy", busy, 1'b0);
        check_bit("busy before done", prev_busy, 1'b1);
        check_bit("out_valid before done", prev_valid, 1'b1);
        if (out_count != `CONV_OUT_N) begin
          $display("CHECK FAILED time %0t out_valid count got %0d expected %0d", $time,
                   out_count, `CONV_OUT_N);
          errors++;
        end
      end
      prev_busy  = busy;
      prev_valid = out_valid;
      cyc++;
    end
    @(posedge clk);
    start  <= 1'b0;
    pix_wr <= 1'b0;
    if (!seen_done) begin
      $display("done did not arrive within %0d cycles after start", RUN_TIMEOUT);
      errors++;
    end
    if (extra_start && !extra_sent) begin
      $display("the run ended before the extra start pulse could be sent");
      errors++;
    end
    // a honoured stray start would show up here as a new busy period.
    repeat (10) begin
      @(negedge clk);
      check_bit("busy", busy, 1'b0);
      check_bit("done", done, 1'b0);
    end
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - errs_at_start);
    end
  endtask

  initial begin
    void'($urandom(32'h5de00d40));
    clk          = 1'b0;
    rst_n        = 1'b0;
    pix_wr       = 1'b0;
    pix_addr     = '0;
    pix_wdata    = '0;
    coef_wr      = 1'b0;
    coef_idx     = '0;
    coef_wdata   = '0;
    start        = 1'b0;
    out_count    = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    errs_before = errors;
    repeat (5) begin
      @(negedge clk);
      check_bit("busy", busy, 1'b0);
      check_bit("out_valid", out_valid, 1'b0);
      check_bit("done", done, 1'b0);
    end
    finish_test("reset state", errs_before);

    errs_before = errors;
    foreach (image[a]) image[a] = pix_pkg::pixel_t'($urandom);
    foreach (kernel[k]) kernel[k] = pix_pkg::coef_t'($urandom);
    load_image();
    load_kernel();
    run_conv(1'b0, 1'b0);
    finish_test("random image and kernel", errs_before);

    errs_before = errors;
    foreach (image[a]) image[a] = 6'd63;
    foreach (kernel[k]) kernel[k] = 6'd63;
    load_image();
    load_kernel();
    run_conv(1'b0, 1'b0);
    finish_test("full scale values", errs_before);

    // a uniform kernel would hide pixels that land in the wrong window slot.
    errs_before = errors;
    foreach (image[a]) image[a] = pix_pkg::pixel_t'($urandom);
    foreach (kernel[k]) kernel[k] = pix_pkg::coef_t'($urandom);
    load_image();
    load_kernel();
    run_conv(1'b1, 1'b0);
    finish_test("host writes during a run", errs_before);

    errs_before = errors;
    foreach (kernel[k]) kernel[k] = pix_pkg::coef_t'($urandom);
    load_kernel();
    run_conv(1'b0, 1'b1);
    finish_test("new kernel and ignored start", errs_before);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/conv_engine_top.sv
`default_nettype none

`include "conv_defs.svh"

module conv_engine_top (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       pix_wr,
  input  wire [`CONV_ADDR_W-1:0]    pix_addr,
  input  wire pix_pkg::pixel_t      pix_wdata,
  input  wire                       coef_wr,
  input  wire [`CONV_KADDR_W-1:0]   coef_idx,
  input  wire pix_pkg::coef_t       coef_wdata,
  input  wire                       start,
  output logic                      busy,
  output logic                      out_valid,
  output pix_pkg::sum_t             out_data,
  output logic                      done
);

  logic                    rd_req;
  logic [`CONV_ADDR_W-1:0] rd_addr;
  logic                    rd_gnt;
  pix_pkg::pixel_t         rd_data;
  logic                    rd_data_valid;
  logic                    win_valid;
  logic [`CONV_WIN_W-1:0]  win_pix;
  logic                    win_last;
  logic                    sum_valid;
  pix_pkg::sum_t           sum;
  logic                    sum_last;

  feature_mem_arbiter u_feature_mem_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .pix_wr        (pix_wr),
    .pix_addr      (pix_addr),
    .pix_wdata     (pix_wdata),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .rd_gnt        (rd_gnt),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid)
  );

  window_fetcher u_window_fetcher (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .rd_gnt        (rd_gnt),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .busy          (busy),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .win_valid     (win_valid),
    .win_pix       (win_pix),
    .win_last      (win_last)
  );

  conv_5x5 u_conv_5x5 (
    .clk        (clk),
    .rst_n      (rst_n),
    .coef_wr    (coef_wr),
    .coef_idx   (coef_idx),
    .coef_wdata (coef_wdata),
    .win_valid  (win_valid),
    .win_pix    (win_pix),
    .win_last   (win_last),
    .sum_valid  (sum_valid),
    .sum        (sum),
    .sum_last   (sum_last)
  );

  assign out_valid = sum_valid;
  assign out_data  = sum;

  // done follows the result of the last window by one cycle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= sum_valid && sum_last;
    end
  end

endmodule

`default_nettype wire

//--- design/conv_5x5.sv
`default_nettype none

`include "conv_defs.svh"

module conv_5x5 (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       coef_wr,
  input  wire [`CONV_KADDR_W-1:0]   coef_idx,
  input  wire pix_pkg::coef_t       coef_wdata,
  input  wire                       win_valid,
  input  wire [`CONV_WIN_W-1:0]     win_pix,
  input  wire                       win_last,
  output logic                      sum_valid,
  output pix_pkg::sum_t             sum,
  output logic                      sum_last
);

  pix_pkg::coef_t    coef [0:`CONV_KK-1];
  pix_pkg::product_t prod [0:`CONV_KK-1];
  logic              prod_valid;
  logic              prod_last;
  pix_pkg::sum_t     lvl1 [0:12];
  pix_pkg::sum_t     lvl2 [0:6];
  pix_pkg::sum_t     lvl3 [0:3];
  pix_pkg::sum_t     lvl4 [0:1];

  always_ff @(posedge clk) begin
    if (coef_wr && (coef_idx < 5'(`CONV_KK))) begin
      coef[coef_idx] <= coef_wdata;
    end
  end

  // stage one, every window pixel times its coefficient.
  always_ff @(posedge clk) begin
    if (win_valid) begin
      for (int i = 0; i < `CONV_KK; i++) begin
        prod[i] <= pix_pkg::product_t'(win_pix[i*`CONV_PIX_W +: `CONV_PIX_W])
                 * pix_pkg::product_t'(coef[i]);
      end
    end
  end

  // odd counts carry the last element up one level unchanged.
  always_comb begin
    for (int i = 0; i < 12; i++) begin
      lvl1[i] = pix_pkg::sum_t'(prod[2*i]) + pix_pkg::sum_t'(prod[2*i+1]);
    end
    lvl1[12] = pix_pkg::sum_t'(prod[24]);
    for (int i = 0; i < 6; i++) begin
      lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
    end
    lvl2[6] = lvl1[12];
    for (int i = 0; i < 3; i++) begin
      lvl3[i] = lvl2[2*i] + lvl2[2*i+1];
    end
    lvl3[3] = lvl2[6];
    lvl4[0] = lvl3[0] + lvl3[1];
    lvl4[1] = lvl3[2] + lvl3[3]; // carries the 25th product.
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      sum <= lvl4[0] + lvl4[1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
      prod_last  <= 1'b0;
      sum_valid  <= 1'b0;
      sum_last   <= 1'b0;
    end else begin
      prod_valid <= win_valid;
      prod_last  <= win_valid && win_last;
      sum_valid  <= prod_valid;
      sum_last   <= prod_valid && prod_last;
    end
  end

  // the fetcher relies on this fixed latency to time the end of a run.
  a_two_cycle_latency: assert property (
    @(posedge clk) disable iff (!rst_n) win_valid |-> ##2 sum_valid
  );

  a_no_stray_sum: assert property (
    @(posedge clk) disable iff (!rst_n) sum_valid |-> $past(win_valid, 2)
  );

endmodule

`default_nettype wire

//--- design/window_fetcher.sv
`default_nettype none

`include "conv_defs.svh"

module window_fetcher (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      start,
  input  wire                      rd_gnt,
  input  wire pix_pkg::pixel_t     rd_data,
  input  wire                      rd_data_valid,
  output logic                     busy,
  output logic                     rd_req,
  output logic [`CONV_ADDR_W-1:0]  rd_addr,
  output logic                     win_valid,
  output logic [`CONV_WIN_W-1:0]   win_pix,
  output logic                     win_last
);

  ctrl_pkg::fetch_state_t state;
  logic [3:0] orow;    // output row of the current window.
  logic [3:0] ocol;    // output column of the current window.
  logic [3:0] fcol;    // image column being requested.
  logic [2:0] frow;    // row offset inside that column.
  logic [2:0] rx_row;
  logic [3:0] rx_col;  // image column being received.
  logic       issuing;
  logic       drain;
  logic [3:0] row_sel;
  logic       last_pos;
  logic       last_issue_col;
  logic       col_done;
  pix_pkg::pixel_t win [0:`CONV_K-1][0:`CONV_K-1];
  pix_pkg::pixel_t newcol [0:`CONV_K-2];

  assign row_sel = orow + 4'(frow);
  assign rd_addr = `CONV_ADDR_W'(row_sel) * `CONV_ADDR_W'(`CONV_IMG_W) + `CONV_ADDR_W'(fcol);
  assign rd_req  = issuing;

  // the rightmost window column sits CONV_K-1 image columns past ocol.
  assign last_issue_col = (fcol == ocol + 4'(`CONV_K - 1));
  assign col_done       = rd_data_valid && (rx_row == 3'(`CONV_K - 1));
  assign last_pos       = (orow == 4'(`CONV_OUT_H - 1)) && (ocol == 4'(`CONV_OUT_W - 1));

  assign busy      = (state != ctrl_pkg::IDLE);
  assign win_valid = (state == ctrl_pkg::EMIT);
  assign win_last  = win_valid && last_pos;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ctrl_pkg::IDLE;
      orow    <= '0;
      ocol    <= '0;
      fcol    <= '0;
      frow    <= '0;
      rx_row  <= '0;
      rx_col  <= '0;
      issuing <= 1'b0;
      drain   <= 1'b0;
    end else begin
      // requests walk down a column, then move one column right.
      if (rd_req && rd_gnt) begin
        if (frow == 3'(`CONV_K - 1)) begin
          frow <= '0;
          fcol <= fcol + 4'd1;
          if (last_issue_col) begin
            issuing <= 1'b0;
          end
        end else begin
          frow <= frow + 3'd1;
        end
      end

      if (rd_data_valid) begin
        if (col_done) begin
          rx_row <= '0;
          rx_col <= rx_col + 4'd1;
        end else begin
          rx_row <= rx_row + 3'd1;
        end
      end

      case (state)
        ctrl_pkg::IDLE: begin
          if (start) begin
            state   <= ctrl_pkg::PRIME;
            orow    <= '0;
            ocol    <= '0;
            fcol    <= '0;
            rx_col  <= '0;
            issuing <= 1'b1;
          end
        end
        ctrl_pkg::PRIME, ctrl_pkg::SHIFT: begin
          if (col_done && (rx_col == ocol + 4'(`CONV_K - 1))) begin
            state <= ctrl_pkg::EMIT;
          end
        end
        ctrl_pkg::EMIT: begin
          if (last_pos) begin
            state <= ctrl_pkg::FINISH;
            drain <= 1'b0;
          end else if (ocol == 4'(`CONV_OUT_W - 1)) begin
            state   <= ctrl_pkg::PRIME; // a new row primes all five columns again.
            orow    <= orow + 4'd1;
            ocol    <= '0;
            fcol    <= '0;
            rx_col  <= '0;
            issuing <= 1'b1;
          end else begin
            state   <= ctrl_pkg::SHIFT;
            ocol    <= ocol + 4'd1;
            issuing <= 1'b1;
          end
        end
        ctrl_pkg::FINISH: begin
          // two cycles here line busy up with done at the top level.
          drain <= 1'b1;
          if (drain) begin
            state <= ctrl_pkg::IDLE;
          end
        end
        default: state <= ctrl_pkg::IDLE;
      endcase
    end
  end

  // the first four pixels of a column wait in newcol, the fifth goes in directly.
  always_ff @(posedge clk) begin
    if (rd_data_valid && !col_done) begin
      newcol[rx_row[1:0]] <= rd_data;
    end
    if (col_done) begin
      for (int r = 0; r < `CONV_K; r++) begin
        for (int c = 0; c < `CONV_K - 1; c++) begin
          win[r][c] <= win[r][c+1];
        end
      end
      for (int r = 0; r < `CONV_K - 1; r++) begin
        win[r][`CONV_K-1] <= newcol[r];
      end
      win[`CONV_K-1][`CONV_K-1] <= rd_data;
    end
  end

  always_comb begin
    for (int r = 0; r < `CONV_K; r++) begin
      for (int c = 0; c < `CONV_K; c++) begin
        win_pix[(r*`CONV_K+c)*`CONV_PIX_W +: `CONV_PIX_W] = win[r][c];
      end
    end
  end

  // the arbiter may refuse a read for many cycles, the request must not drift.
  a_req_held: assert property (
    @(posedge clk) disable iff (!rst_n) rd_req && !rd_gnt |=> rd_req && $stable(rd_addr)
  );

  a_win_in_busy: assert property (
    @(posedge clk) disable iff (!rst_n) win_valid |-> busy
  );

endmodule

`default_nettype wire

//--- design/feature_mem_arbiter.sv
`default_nettype none

`include "conv_defs.svh"

module feature_mem_arbiter (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      pix_wr,
  input  wire [`CONV_ADDR_W-1:0]   pix_addr,
  input  wire pix_pkg::pixel_t     pix_wdata,
  input  wire                      rd_req,
  input  wire [`CONV_ADDR_W-1:0]   rd_addr,
  output logic                     rd_gnt,
  output pix_pkg::pixel_t          rd_data,
  output logic                     rd_data_valid
);

  pix_pkg::pixel_t mem [0:`CONV_IMG_W*`CONV_IMG_H-1];
  ctrl_pkg::mem_client_t grant;

  // the host has no way to wait, so it always wins the port.
  always_comb begin
    if (pix_wr) begin
      grant = ctrl_pkg::HOST;
    end else if (rd_req) begin
      grant = ctrl_pkg::FETCH;
    end else begin
      grant = ctrl_pkg::NONE;
    end
  end

  assign rd_gnt = (grant == ctrl_pkg::FETCH);

  always_ff @(posedge clk) begin
    if (grant == ctrl_pkg::HOST) begin
      mem[pix_addr] <= pix_wdata;
    end
    if (grant == ctrl_pkg::FETCH) begin
      rd_data <= mem[rd_addr]; // one cycle of read latency.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= rd_gnt;
    end
  end

  // a single-port RAM cannot serve a write and a read in one cycle.
  a_no_read_on_write: assert property (
    @(posedge clk) disable iff (!rst_n) pix_wr |-> !rd_gnt
  );

endmodule

`default_nettype wire

//--- design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE,
    PRIME,  // loads all five columns at the start of an output row.
    SHIFT,  // loads the one incoming column.
    EMIT,
    FINISH  // waits for the last sum to leave conv_5x5.
  } fetch_state_t;

  // owner of the pixel RAM port in the current cycle.
  typedef enum logic [1:0] {
    NONE,
    HOST,
    FETCH
  } mem_client_t;

endpackage

`default_nettype wire

//--- design/pix_pkg.sv
`default_nettype none

`include "conv_defs.svh"

package pix_pkg;

  // pixels and coefficients share the same unsigned width.
  typedef logic [`CONV_PIX_W-1:0] pixel_t;
  typedef logic [`CONV_PIX_W-1:0] coef_t;

  typedef logic [`CONV_PROD_W-1:0] product_t; // one pixel times one coefficient.

  // 25 full-scale products fit, 25 * 63 * 63 is 99225.
  typedef logic [`CONV_SUM_W-1:0] sum_t;

endpackage

`default_nettype wire

//--- design/conv_defs.svh
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// image geometry, pixel address is row * CONV_IMG_W + column.
`define CONV_IMG_W   16
`define CONV_IMG_H   16
`define CONV_ADDR_W  8

// kernel geometry, coefficient index is row * CONV_K + column.
`define CONV_K       5
`define CONV_KK      25
`define CONV_KADDR_W 5

// valid output positions without padding.
`define CONV_OUT_W   12
`define CONV_OUT_H   12
`define CONV_OUT_N   (`CONV_OUT_W * `CONV_OUT_H)

`define CONV_PIX_W   6
`define CONV_PROD_W  12
`define CONV_SUM_W   18
`define CONV_WIN_W   (`CONV_KK * `CONV_PIX_W)

`endif
